// ==== design/ising_pkg.sv ====
/* Array size, coupling weight codes and delay depth for the oscillator array */
`default_nettype none

package ising_pkg;

    // Number of oscillators, also the side of the square coupling array
    localparam int num_spins = 4;

    // Width of a row or column index
    localparam int idx_w = 2;

    // Clocked stages per delay chain inside one cell
    localparam int delay_depth = 3;

    // Coupling weight codes, from strongest negative to strongest positive
    // Codes 5 to 7 carry no meaning and behave as w_zero
    typedef enum logic [2:0] {
        w_neg2 = 3'd0,
        w_neg1 = 3'd1,
        w_zero = 3'd2,
        w_pos1 = 3'd3,
        w_pos2 = 3'd4
    } weight_e;

endpackage

`default_nettype wire

// ==== design/readout_pkg.sv ====
/* Readout state encoding, run lengths and counter sizing */
`default_nettype none

package readout_pkg;

    // Cycles the array runs freely before the phase is sampled
    localparam int settle_cycles = 64;

    // Number of cycles over which phase agreement is counted
    localparam int window_cycles = 32;

    // Wide enough for the longer of the two runs above
    localparam int cnt_w = 7;

    typedef logic [cnt_w-1:0] cnt_t;

    // Run sequencing
    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_settle,
        st_sample,
        st_done
    } rd_state_e;

endpackage

`default_nettype wire

// ==== design/weight_regs.sv ====
/* Coupling weight storage, one code per array cell, written by a plain strobe */
`default_nettype none
`timescale 1ns/10ps

module weight_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                wr_en,
    input  logic [ising_pkg::idx_w-1:0]         wr_row,
    input  logic [ising_pkg::idx_w-1:0]         wr_col,
    input  ising_pkg::weight_e                  wr_weight,
    output ising_pkg::weight_e [ising_pkg::num_spins*ising_pkg::num_spins-1:0] weights
);

    ising_pkg::weight_e wr_code;

    // Out of range codes are folded to zero coupling before storage
    assign wr_code = (wr_weight > ising_pkg::w_pos2) ? ising_pkg::w_zero : wr_weight;

    // Flat index is row * num_spins + column
    for (genvar r = 0; r < ising_pkg::num_spins; r++) begin : g_row
        for (genvar c = 0; c < ising_pkg::num_spins; c++) begin : g_col
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    weights[r*ising_pkg::num_spins+c] <= ising_pkg::w_zero;
                end else if (wr_en && (wr_row == ising_pkg::idx_w'(r))
                             && (wr_col == ising_pkg::idx_w'(c))) begin
                    weights[r*ising_pkg::num_spins+c] <= wr_code;
                end
            end
        end
    end

    // A write with an unknown address would corrupt an unpredictable cell
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown({wr_row, wr_col})
    );

endmodule

`default_nettype wire

// ==== design/coupled_cell.sv ====
/* Coupling cell with clocked source and destination delay chains and
   weight dependent tap selection */
`default_nettype none
`timescale 1ns/10ps

module coupled_cell (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               load,
    input  logic               load_s,
    input  logic               load_d,
    input  ising_pkg::weight_e weight,
    input  logic               sin,
    input  logic               din,
    output logic               sout,
    output logic               dout
);

    logic [ising_pkg::delay_depth-1:0] s_q;
    logic [ising_pkg::delay_depth-1:0] d_q;
    logic mismatch;
    logic neg2, neg1, pos1, pos2;
    logic slow1, slow2;

    // One hot decode of the weight, illegal codes hit nothing
    assign neg2 = (weight == ising_pkg::w_neg2);
    assign neg1 = (weight == ising_pkg::w_neg1);
    assign pos1 = (weight == ising_pkg::w_pos1);
    assign pos2 = (weight == ising_pkg::w_pos2);

    // Compare first stages so no path runs from an output back to a select
    assign mismatch = s_q[0] ^ d_q[0];

    // Positive coupling delays on mismatch, negative coupling delays on match
    // Both chains see the same stages, so one select serves both
    assign slow1 = (neg1 & ~mismatch) | (pos1 & mismatch);
    assign slow2 = (neg2 & ~mismatch) | (pos2 & mismatch);

    // Stage 0 takes the input, higher stages follow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_q <= '0;
            d_q <= '0;
        end else if (load) begin
            s_q <= {ising_pkg::delay_depth{load_s}};
            d_q <= {ising_pkg::delay_depth{load_d}};
        end else if (run) begin
            s_q <= {s_q[ising_pkg::delay_depth-2:0], sin};
            d_q <= {d_q[ising_pkg::delay_depth-2:0], din};
        end
    end

    // Longest tap when slowed by two, middle tap when slowed by one
    assign sout = slow2 ? s_q[ising_pkg::delay_depth-1] :
                  slow1 ? s_q[1] :
                          s_q[0];

    assign dout = slow2 ? d_q[ising_pkg::delay_depth-1] :
                  slow1 ? d_q[1] :
                          d_q[0];

    // Readout never presets the chains while they advance
    a_load_run_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && run)
    );

endmodule

`default_nettype wire

// ==== design/oscillator_array.sv ====
/* N by N coupling array, ring closure through an inversion and ring presets */
`default_nettype none
`timescale 1ns/10ps

module oscillator_array (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               run,
    input  logic                               load,
    input  logic [ising_pkg::num_spins-1:0]    init_level,
    input  ising_pkg::weight_e [ising_pkg::num_spins*ising_pkg::num_spins-1:0] weights,
    output logic [ising_pkg::num_spins-1:0]    osc
);

    localparam int n = ising_pkg::num_spins;

    // Indexed [row][column]
    logic [n-1:0][n-1:0] s_in;
    logic [n-1:0][n-1:0] s_out;
    logic [n-1:0][n-1:0] d_in;
    logic [n-1:0][n-1:0] d_out;

    for (genvar r = 0; r < n; r++) begin : g_row
        for (genvar c = 0; c < n; c++) begin : g_col

            // Source chain of ring r enters row r from the bottom of column r
            if (c == 0) begin : g_s_head
                assign s_in[r][c] = d_out[n-1][r];
            end else begin : g_s_link
                assign s_in[r][c] = s_out[r][c-1];
            end

            // Destination chain of ring c enters column c inverted from the end of row c
            if (r == 0) begin : g_d_head
                assign d_in[r][c] = ~s_out[c][n-1];
            end else begin : g_d_link
                assign d_in[r][c] = d_out[r-1][c];
            end

            // Source chain belongs to ring r, destination chain to ring c
            coupled_cell u_cell (
                .clk    (clk),
                .rst_n  (rst_n),
                .run    (run),
                .load   (load),
                .load_s (init_level[r]),
                .load_d (init_level[c]),
                .weight (weights[r*n+c]),
                .sin    (s_in[r][c]),
                .din    (d_in[r][c]),
                .sout   (s_out[r][c]),
                .dout   (d_out[r][c])
            );
        end

        // Each ring is observed at its own diagonal cell
        assign osc[r] = s_out[r][r];
    end

endmodule

`default_nettype wire

// ==== design/phase_readout.sv ====
/* Run sequencer with phase agreement counters and spin decision */
`default_nettype none
`timescale 1ns/10ps

module phase_readout (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [ising_pkg::num_spins-1:0]  osc,
    output logic                             run,
    output logic                             load,
    output logic                             busy,
    output logic                             done,
    output logic [ising_pkg::num_spins-2:0]  spins
);

    readout_pkg::rd_state_e state_q;
    readout_pkg::cnt_t      seq_cnt_q;
    readout_pkg::cnt_t [ising_pkg::num_spins-1:1] match_q;
    readout_pkg::cnt_t [ising_pkg::num_spins-1:1] match_nxt;
    logic [ising_pkg::num_spins-2:0] spin_dec;
    logic settle_end;
    logic window_end;

    assign settle_end = (seq_cnt_q == readout_pkg::cnt_t'(readout_pkg::settle_cycles - 1));
    assign window_end = (seq_cnt_q == readout_pkg::cnt_t'(readout_pkg::window_cycles - 1));

    // Agreement with oscillator 0 counted including the current cycle
    // Mostly in phase means spin 0, otherwise spin 1
    always_comb begin
        for (int k = 1; k < ising_pkg::num_spins; k++) begin
            match_nxt[k] = match_q[k] + readout_pkg::cnt_t'(osc[k] == osc[0]);
            spin_dec[k-1] = (match_nxt[k] <=
                             readout_pkg::cnt_t'(readout_pkg::window_cycles / 2));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= readout_pkg::st_idle;
            seq_cnt_q <= '0;
            match_q   <= '0;
            spins     <= '0;
        end else begin
            case (state_q)
                // Start is only seen here, so a pulse during a run is dropped
                readout_pkg::st_idle: begin
                    if (start) begin
                        state_q <= readout_pkg::st_load;
                    end
                end
                readout_pkg::st_load: begin
                    state_q   <= readout_pkg::st_settle;
                    seq_cnt_q <= '0;
                    match_q   <= '0;
                end
                readout_pkg::st_settle: begin
                    if (settle_end) begin
                        state_q   <= readout_pkg::st_sample;
                        seq_cnt_q <= '0;
                    end else begin
                        seq_cnt_q <= seq_cnt_q + readout_pkg::cnt_t'(1);
                    end
                end
                readout_pkg::st_sample: begin
                    match_q <= match_nxt;
                    if (window_end) begin
                        state_q <= readout_pkg::st_done;
                        // Result becomes visible together with done
                        spins   <= spin_dec;
                    end else begin
                        seq_cnt_q <= seq_cnt_q + readout_pkg::cnt_t'(1);
                    end
                end
                readout_pkg::st_done: begin
                    state_q <= readout_pkg::st_idle;
                end
                default: begin
                    state_q <= readout_pkg::st_idle;
                end
            endcase
        end
    end

    // Array advances through settle and sample, held otherwise
    assign load = (state_q == readout_pkg::st_load);
    assign run  = (state_q == readout_pkg::st_settle) || (state_q == readout_pkg::st_sample);
    assign busy = (state_q != readout_pkg::st_idle);
    assign done = (state_q == readout_pkg::st_done);

    // Done is a single cycle marker, never two in a row
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    );

endmodule

`default_nettype wire

// ==== design/ising_core.sv ====
/* Ising core top level with weight storage, oscillator array and readout */
`default_nettype none
`timescale 1ns/10ps

module ising_core (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wr_en,
    input  logic [ising_pkg::idx_w-1:0]      wr_row,
    input  logic [ising_pkg::idx_w-1:0]      wr_col,
    input  ising_pkg::weight_e               wr_weight,
    input  logic                             start,
    input  logic [ising_pkg::num_spins-1:0]  init_level,
    output logic                             busy,
    output logic                             done,
    output logic [ising_pkg::num_spins-2:0]  spins
);

    ising_pkg::weight_e [ising_pkg::num_spins*ising_pkg::num_spins-1:0] weights;
    logic run;
    logic load;
    logic [ising_pkg::num_spins-1:0] osc;

    weight_regs u_weight_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_row    (wr_row),
        .wr_col    (wr_col),
        .wr_weight (wr_weight),
        .weights   (weights)
    );

    // Rings preset straight from the start level on the load cycle
    oscillator_array u_oscillator_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .load       (load),
        .init_level (init_level),
        .weights    (weights),
        .osc        (osc)
    );

    phase_readout u_phase_readout (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .osc   (osc),
        .run   (run),
        .load  (load),
        .busy  (busy),
        .done  (done),
        .spins (spins)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
/* Free running 4 ns testbench clock */
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk
);

    // Starts low, first rising edge at 2 ns
    initial clk = 1'b0;

    always #2 clk = ~clk;

endmodule

`default_nettype wire

// ==== testbench/tb_ising_core.sv ====
/* Ising core testbench with LFSR stimulus, a cycle model of the coupled
   array and readout, result, timing and hold checks */
`default_nettype none
`timescale 1ns/10ps

module tb_ising_core;

    localparam int n = ising_pkg::num_spins;
    localparam int settle = readout_pkg::settle_cycles;
    localparam int window = readout_pkg::window_cycles;
    // Falling edges from the start drive to the first one that sees done
    localparam int run_len = settle + window + 2;

    logic clk;
    logic rst_n;
    logic wr_en;
    logic [ising_pkg::idx_w-1:0] wr_row;
    logic [ising_pkg::idx_w-1:0] wr_col;
    ising_pkg::weight_e wr_weight;
    logic start;
    logic [n-1:0] init_level;
    logic busy;
    logic done;
    logic [n-2:0] spins;

    logic [31:0] lfsr_q;
    logic [2:0] model_w [n*n];
    logic [n-2:0] exp_spins;
    int errors;
    int checks;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    ising_core u_ising_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_row     (wr_row),
        .wr_col     (wr_col),
        .wr_weight  (wr_weight),
        .start      (start),
        .init_level (init_level),
        .busy       (busy),
        .done       (done),
        .spins      (spins)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int nbits, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            val = {val[6:0], lfsr_q[0]};
        end
    endtask

    // Positive weights slow a chain on mismatch, negative weights on match
    function automatic logic [1:0] tap_index(input logic [2:0] w, input logic mism);
        if ((w == ising_pkg::w_pos2 && mism) || (w == ising_pkg::w_neg2 && !mism)) begin
            return 2'(ising_pkg::delay_depth - 1);
        end
        if ((w == ising_pkg::w_pos1 && mism) || (w == ising_pkg::w_neg1 && !mism)) begin
            return 2'd1;
        end
        return 2'd0;
    endfunction

    // Cycle model of load, settle and sample, returns spins 1 to n-1
    function automatic logic [n-2:0] expected_spins(input logic [n-1:0] init);
        logic [ising_pkg::delay_depth-1:0] s_st [n][n];
        logic [ising_pkg::delay_depth-1:0] d_st [n][n];
        logic s_o [n][n];
        logic d_o [n][n];
        logic [1:0] tap;
        int cnt [n];
        logic [n-2:0] res;
        // Source chains take the row level, destination chains the column level
        for (int r = 0; r < n; r++) begin
            cnt[r] = 0;
            for (int c = 0; c < n; c++) begin
                s_st[r][c] = {ising_pkg::delay_depth{init[r]}};
                d_st[r][c] = {ising_pkg::delay_depth{init[c]}};
            end
        end
        for (int t = 0; t < settle + window; t++) begin
            for (int r = 0; r < n; r++) begin
                for (int c = 0; c < n; c++) begin
                    tap = tap_index(model_w[r*n+c], s_st[r][c][0] ^ d_st[r][c][0]);
                    s_o[r][c] = s_st[r][c][tap];
                    d_o[r][c] = d_st[r][c][tap];
                end
            end
            // Agreement with ring 0 counts only inside the window
            if (t >= settle) begin
                for (int k = 1; k < n; k++) begin
                    if (s_o[k][k] == s_o[0][0]) begin
                        cnt[k]++;
                    end
                end
            end
            // Row k feeds from column k bottom, column k from inverted row k end
            for (int r = 0; r < n; r++) begin
                for (int c = 0; c < n; c++) begin
                    s_st[r][c] = {s_st[r][c][ising_pkg::delay_depth-2:0],
                                  (c == 0) ? d_o[n-1][r] : s_o[r][c-1]};
                    d_st[r][c] = {d_st[r][c][ising_pkg::delay_depth-2:0],
                                  (r == 0) ? ~s_o[c][n-1] : d_o[r-1][c]};
                end
            end
        end
        for (int k = 1; k < n; k++) begin
            res[k-1] = (cnt[k] > window / 2) ? 1'b0 : 1'b1;
        end
        return res;
    endfunction

    // Called on a falling edge, returns one falling edge later
    task automatic write_weight(input int row, input int col, input logic [2:0] code);
        wr_en = 1'b1;
        wr_row = ising_pkg::idx_w'(row);
        wr_col = ising_pkg::idx_w'(col);
        wr_weight = ising_pkg::weight_e'(code);
        // Illegal codes act as zero coupling
        model_w[row*n+col] = (code > 3'd4) ? ising_pkg::w_zero : code;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // Rewrites every cell while the last result must stay put
    task automatic program_random_weights();
        logic [7:0] val;
        logic [n-2:0] held;
        held = spins;
        for (int i = 0; i < n * n; i++) begin
            draw_bits(3, val);
            write_weight(i / n, i % n, val[2:0]);
            check_value("spins_hold", 32'(spins), 32'(held));
        end
        draw_bits(5, val);
        write_weight(int'(val[4:3]), int'(val[2:1]), val[0] ? 3'd7 : 3'd5);
        check_value("spins_hold", 32'(spins), 32'(held));
    endtask

    // One run with busy span and done timing, poke pulses start mid run
    task automatic do_run(input logic [n-1:0] init, input bit poke);
        int cyc;
        logic [7:0] junk;
        exp_spins = expected_spins(init);
        start = 1'b1;
        init_level = init;
        @(negedge clk);
        start = 1'b0;
        cyc = 1;
        while (!done && cyc < run_len + 20) begin
            check_value("busy", 32'(busy), 32'd1);
            if (poke && cyc == 10) begin
                draw_bits(n, junk);
                start = 1'b1;
                init_level = junk[n-1:0];
            end else begin
                start = 1'b0;
            end
            @(negedge clk);
            cyc++;
        end
        if (!done) begin
            errors++;
            $display("Timeout: done did not arrive within %0d cycles of start", run_len + 20);
        end else begin
            check_value("done_cycle", cyc, run_len);
        end
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
    endtask

    task automatic report_and_finish();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // Result checker on the falling edge, where outputs are settled
    initial begin : result_check
        forever begin
            @(negedge clk);
            if (rst_n && done) begin
                check_value("busy", 32'(busy), 32'd1);
                check_value("spins", 32'(spins), 32'(exp_spins));
            end
        end
    end

    initial begin : stimulus
        logic [7:0] val;
        logic [n-2:0] xor_exp;
        errors = 0;
        checks = 0;
        lfsr_q = 32'h5275;
        exp_spins = '0;
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_row = '0;
        wr_col = '0;
        wr_weight = ising_pkg::w_zero;
        start = 1'b0;
        init_level = '0;
        for (int i = 0; i < n * n; i++) begin
            model_w[i] = ising_pkg::w_zero;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("spins", 32'(spins), 32'd0);

        // Equal ring periods, so each spin is just the start level difference
        for (int i = 0; i < 4; i++) begin
            draw_bits(n, val);
            do_run(val[n-1:0], 1'b0);
            for (int k = 1; k < n; k++) begin
                xor_exp[k-1] = val[k] ^ val[0];
            end
            check_value("spins_xor", 32'(spins), 32'(xor_exp));
        end

        // Random couplings, some runs see a stray start while busy
        for (int run = 0; run < 20; run++) begin
            program_random_weights();
            draw_bits(n, val);
            do_run(val[n-1:0], (run % 4) == 1);
        end

        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/ising_pkg.sv
design/readout_pkg.sv
design/weight_regs.sv
design/coupled_cell.sv
design/oscillator_array.sv
design/phase_readout.sv
design/ising_core.sv
testbench/tb_clock_gen.sv
testbench/tb_ising_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the Ising core testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_ising_core -o tb_ising_core

./obj_dir/tb_ising_core > sim.log 2>&1
cat sim.log

if ! grep -q "TESTS PASSED" sim.log; then
    echo "Simulation did not pass, see sim.log"
    exit 1
fi
